//--- hdl/core_pkg.sv
package core_pkg;

  // ############################################################
  // machine constants
  // ############################################################

  localparam int unsigned xlen = 32;
  localparam logic [xlen-1:0] reset_vector = 32'h0000_0000;
  localparam logic [xlen-1:0] trap_vector = 32'h0000_0100;
  localparam logic [31:0] nop_instr = 32'h0000_0013; // addi x0,x0,0.

  // ############################################################
  // encodings
  // ############################################################

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    bcu_none, bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu
  } bcu_op_t;

  typedef enum logic [3:0] {
    lsu_none, lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu, lsu_sb, lsu_sh, lsu_sw
  } lsu_op_t;

  // riscv mcause numbering.
  typedef enum logic [3:0] {
    exc_instr_misaligned = 4'd0,
    exc_load_misaligned  = 4'd4,
    exc_store_misaligned = 4'd6
  } ecause_t;

endpackage

//--- hdl/predecoder.sv
`timescale 1ns/100ps

module predecoder (
  input  logic [31:0]       instr,
  output logic              valid,
  output logic [31:0]       imm,
  output logic              wren,
  output logic              rden1,
  output logic              rden2,
  output logic              lui,
  output logic              auipc,
  output logic              jal,
  output logic              jalr,
  output logic              branch,
  output logic              load,
  output logic              store,
  output core_pkg::alu_op_t alu_op,
  output core_pkg::bcu_op_t bcu_op,
  output core_pkg::lsu_op_t lsu_op
);
  import core_pkg::*;

  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    valid = 1'b1;
    imm = '0;
    wren = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    lui = 1'b0;
    auipc = 1'b0;
    jal = 1'b0;
    jalr = 1'b0;
    branch = 1'b0;
    load = 1'b0;
    store = 1'b0;
    alu_op = alu_add;
    bcu_op = bcu_none;
    lsu_op = lsu_none;
    case (instr[6:0])
      opc_lui: begin
        imm = imm_u;
        wren = 1'b1;
        lui = 1'b1;
      end
      opc_auipc: begin
        imm = imm_u;
        wren = 1'b1;
        auipc = 1'b1;
      end
      opc_jal: begin
        imm = imm_j;
        wren = 1'b1;
        jal = 1'b1;
      end
      opc_jalr: begin
        imm = imm_i;
        wren = 1'b1;
        rden1 = 1'b1;
        jalr = 1'b1;
        valid = (funct3 == 3'b000);
      end
      opc_branch: begin
        imm = imm_b;
        rden1 = 1'b1;
        rden2 = 1'b1;
        branch = 1'b1;
        case (funct3)
          3'b000: bcu_op = bcu_beq;
          3'b001: bcu_op = bcu_bne;
          3'b100: bcu_op = bcu_blt;
          3'b101: bcu_op = bcu_bge;
          3'b110: bcu_op = bcu_bltu;
          3'b111: bcu_op = bcu_bgeu;
          default: valid = 1'b0;
        endcase
      end
      opc_load: begin
        imm = imm_i;
        wren = 1'b1;
        rden1 = 1'b1;
        load = 1'b1;
        case (funct3)
          3'b000: lsu_op = lsu_lb;
          3'b001: lsu_op = lsu_lh;
          3'b010: lsu_op = lsu_lw;
          3'b100: lsu_op = lsu_lbu;
          3'b101: lsu_op = lsu_lhu;
          default: valid = 1'b0;
        endcase
      end
      opc_store: begin
        imm = imm_s;
        rden1 = 1'b1;
        rden2 = 1'b1;
        store = 1'b1;
        case (funct3)
          3'b000: lsu_op = lsu_sb;
          3'b001: lsu_op = lsu_sh;
          3'b010: lsu_op = lsu_sw;
          default: valid = 1'b0;
        endcase
      end
      opc_op_imm, opc_op: begin
        imm = imm_i;
        wren = 1'b1;
        rden1 = 1'b1;
        rden2 = instr[5]; // register form.
        case (funct3)
          3'b000: alu_op = (instr[5] & funct7[5]) ? alu_sub : alu_add;
          3'b001: alu_op = alu_sll;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b101: alu_op = funct7[5] ? alu_sra : alu_srl;
          3'b110: alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
        // funct7 only carries the sub/sra bit, and only where it means something.
        if (instr[5] | (funct3 == 3'b001) | (funct3 == 3'b101)) begin
          valid = ((funct7 & 7'b1011111) == 7'b0) &
                  (~funct7[5] | (funct3 == 3'b101) | (instr[5] & (funct3 == 3'b000)));
        end
      end
      default: valid = 1'b0;
    endcase
    if (!valid) begin
      wren = 1'b0;
      rden1 = 1'b0;
      rden2 = 1'b0;
      lui = 1'b0;
      auipc = 1'b0;
      jal = 1'b0;
      jalr = 1'b0;
      branch = 1'b0;
      load = 1'b0;
      store = 1'b0;
      bcu_op = bcu_none;
      lsu_op = lsu_none;
    end
  end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic                      clk,
  input  logic [4:0]                raddr1,
  input  logic [4:0]                raddr2,
  input  logic [4:0]                waddr,
  input  logic                      wren,
  input  logic [core_pkg::xlen-1:0] wdata,
  output logic [core_pkg::xlen-1:0] rdata1,
  output logic [core_pkg::xlen-1:0] rdata2
);
  import core_pkg::*;

  logic [xlen-1:0] regs [0:31];

  always_ff @(posedge clk) begin
    if (wren && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // read sees the old value on a same-cycle write.
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- hdl/bcu.sv
`timescale 1ns/100ps

module bcu (
  input  logic [core_pkg::xlen-1:0] rdata1,
  input  logic [core_pkg::xlen-1:0] rdata2,
  input  core_pkg::bcu_op_t         bcu_op,
  output logic                      taken
);
  import core_pkg::*;

  logic eq;
  logic lt;
  logic ltu;

  assign eq = (rdata1 == rdata2);
  assign lt = ($signed(rdata1) < $signed(rdata2));
  assign ltu = (rdata1 < rdata2);

  always_comb begin
    case (bcu_op)
      bcu_beq: taken = eq;
      bcu_bne: taken = ~eq;
      bcu_blt: taken = lt;
      bcu_bge: taken = ~lt;
      bcu_bltu: taken = ltu;
      bcu_bgeu: taken = ~ltu;
      default: taken = 1'b0;
    endcase
  end

endmodule

//--- hdl/agu.sv
`timescale 1ns/100ps

module agu (
  input  logic [core_pkg::xlen-1:0] pc,
  input  logic [core_pkg::xlen-1:0] rdata1,
  input  logic [core_pkg::xlen-1:0] rdata2,
  input  logic [core_pkg::xlen-1:0] imm,
  input  logic                      jal,
  input  logic                      jalr,
  input  logic                      branch,
  input  logic                      auipc,
  input  core_pkg::lsu_op_t         lsu_op,
  output logic [core_pkg::xlen-1:0] address,
  output logic [3:0]                byteenable,
  output logic [core_pkg::xlen-1:0] wdata,
  output logic                      exception,
  output core_pkg::ecause_t         ecause
);
  import core_pkg::*;

  logic misaligned;

  always_comb begin
    if (jalr) begin
      address = (rdata1 + imm) & ~32'd1;
    end else if (jal | branch | auipc) begin
      address = pc + imm; // pc relative.
    end else begin
      address = rdata1 + imm;
    end
    byteenable = 4'h0;
    wdata = rdata2;
    misaligned = 1'b0;
    case (lsu_op)
      lsu_lb, lsu_lbu, lsu_sb: begin
        byteenable = 4'b0001 << address[1:0];
        wdata = {4{rdata2[7:0]}};
      end
      lsu_lh, lsu_lhu, lsu_sh: begin
        byteenable = 4'b0011 << {address[1], 1'b0};
        wdata = {2{rdata2[15:0]}};
        misaligned = address[0];
      end
      lsu_lw, lsu_sw: begin
        byteenable = 4'hf;
        misaligned = |address[1:0];
      end
      default: ;
    endcase
    exception = 1'b0;
    ecause = exc_instr_misaligned;
    if ((jal | jalr | branch) && address[1:0] != 2'b00) begin
      exception = 1'b1;
    end else if (misaligned) begin
      exception = 1'b1;
      if (lsu_op inside {lsu_sb, lsu_sh, lsu_sw}) begin
        ecause = exc_store_misaligned;
      end else begin
        ecause = exc_load_misaligned;
      end
    end
  end

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [31:0]               imem_rdata,
  input  logic                      imem_ready,
  input  logic                      stall,
  input  logic                      clear,
  input  logic                      pd_valid,
  input  logic [31:0]               pd_imm,
  input  logic                      pd_wren,
  input  logic                      pd_rden1,
  input  logic                      pd_rden2,
  input  logic                      pd_lui,
  input  logic                      pd_auipc,
  input  logic                      pd_jal,
  input  logic                      pd_jalr,
  input  logic                      pd_branch,
  input  logic                      pd_load,
  input  logic                      pd_store,
  input  core_pkg::alu_op_t         pd_alu_op,
  input  core_pkg::bcu_op_t         pd_bcu_op,
  input  core_pkg::lsu_op_t         pd_lsu_op,
  input  logic [core_pkg::xlen-1:0] rdata1,
  input  logic [core_pkg::xlen-1:0] rdata2,
  input  logic                      taken,
  input  logic [core_pkg::xlen-1:0] address,
  input  logic [3:0]                byteenable,
  input  logic [core_pkg::xlen-1:0] agu_wdata,
  input  logic                      exception,
  input  core_pkg::ecause_t         ecause,
  output logic [core_pkg::xlen-1:0] imem_addr,
  output logic [31:0]               instr,
  output logic [4:0]                raddr1,
  output logic [4:0]                raddr2,
  output core_pkg::bcu_op_t         bcu_op,
  output logic [core_pkg::xlen-1:0] pc,
  output logic [31:0]               imm,
  output logic                      jal,
  output logic                      jalr,
  output logic                      branch,
  output logic                      auipc,
  output core_pkg::lsu_op_t         lsu_op,
  output logic                      dmem_valid,
  output logic [core_pkg::xlen-1:0] dmem_addr,
  output logic [core_pkg::xlen-1:0] dmem_wdata,
  output logic [3:0]                dmem_wstrb,
  output logic                      dec_valid,
  output logic [core_pkg::xlen-1:0] dec_pc,
  output logic [31:0]               dec_instr,
  output logic [31:0]               dec_imm,
  output logic                      dec_wren,
  output logic [4:0]                dec_waddr,
  output logic [core_pkg::xlen-1:0] dec_rdata1,
  output logic [core_pkg::xlen-1:0] dec_rdata2,
  output core_pkg::alu_op_t         dec_alu_op,
  output core_pkg::lsu_op_t         dec_lsu_op,
  output logic                      dec_jump,
  output logic                      dec_exception,
  output core_pkg::ecause_t         dec_ecause
);
  import core_pkg::*;

  logic            run; // low for the first cycle after reset.
  logic            stalled;
  logic            wren;
  logic            jump;
  logic            ld;
  logic            st;
  logic            exc;
  lsu_op_t         lsu;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] npc;

  // ############################################################
  // decode, suppression and next pc
  // ############################################################

  always_comb begin
    stalled = ~run | ~imem_ready | stall | clear;
    instr = clear ? nop_instr : imem_rdata;
    raddr1 = instr[19:15];
    raddr2 = instr[24:20];
    imm = pd_imm;
    jal = pd_jal;
    jalr = pd_jalr;
    branch = pd_branch;
    auipc = pd_auipc;
    bcu_op = pd_bcu_op;
    lsu_op = pd_lsu_op;

    // first alu operand carries pc for auipc and zero for lui.
    if (pd_auipc) begin
      op1 = pc;
    end else if (pd_rden1 & ~pd_lui) begin
      op1 = rdata1;
    end else begin
      op1 = '0;
    end
    op2 = pd_rden2 ? rdata2 : '0;

    wren = pd_wren;
    ld = pd_load;
    st = pd_store;
    lsu = pd_lsu_op;
    jump = pd_jal | pd_jalr | taken;
    exc = exception;

    if (stalled) begin
      wren = 1'b0;
      ld = 1'b0;
      st = 1'b0;
      lsu = lsu_none;
      jump = 1'b0;
    end

    // a misaligned access or target cancels itself.
    if (exc) begin
      if (ld) begin
        ld = 1'b0;
        wren = 1'b0;
        lsu = lsu_none;
      end else if (st) begin
        st = 1'b0;
        lsu = lsu_none;
      end else if (jump) begin
        jump = 1'b0;
        wren = 1'b0;
      end else begin
        exc = 1'b0;
      end
    end

    if (exc) begin
      npc = trap_vector;
    end else if (jump) begin
      npc = address;
    end else if (!stalled) begin
      npc = pc + 32'd4;
    end else begin
      npc = pc;
    end

    imem_addr = pc;
    dmem_valid = ld | st;
    dmem_addr = address;
    dmem_wdata = agu_wdata;
    dmem_wstrb = st ? byteenable : 4'h0; // loads write nothing.
  end

  // ############################################################
  // pc and registered decode
  // ############################################################

  always_ff @(posedge clk) begin
    if (!rst) begin
      run <= 1'b0;
      pc <= reset_vector;
      dec_valid <= 1'b0;
      dec_wren <= 1'b0;
      dec_jump <= 1'b0;
      dec_exception <= 1'b0;
    end else begin
      run <= 1'b1;
      pc <= npc;
      dec_valid <= pd_valid & ~stalled;
      dec_wren <= wren;
      dec_jump <= jump;
      dec_exception <= exc;
    end
  end

  always_ff @(posedge clk) begin
    dec_pc <= pc;
    dec_instr <= instr;
    dec_imm <= pd_imm;
    dec_waddr <= instr[11:7];
    dec_rdata1 <= op1;
    dec_rdata2 <= op2;
    dec_alu_op <= pd_alu_op;
    dec_lsu_op <= lsu;
    dec_ecause <= ecause;
  end

  // misaligned targets trap, so the pc stays word aligned.
  assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00);
  assert property (@(posedge clk) disable iff (!rst) !(dec_jump && dec_exception));

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [31:0]               imem_rdata,
  input  logic                      imem_ready,
  input  logic                      stall,
  input  logic                      clear,
  input  logic                      wb_wren,
  input  logic [4:0]                wb_waddr,
  input  logic [core_pkg::xlen-1:0] wb_wdata,
  output logic [core_pkg::xlen-1:0] imem_addr,
  output logic                      dmem_valid,
  output logic [core_pkg::xlen-1:0] dmem_addr,
  output logic [core_pkg::xlen-1:0] dmem_wdata,
  output logic [3:0]                dmem_wstrb,
  output logic                      dec_valid,
  output logic [core_pkg::xlen-1:0] dec_pc,
  output logic [31:0]               dec_instr,
  output logic [31:0]               dec_imm,
  output logic                      dec_wren,
  output logic [4:0]                dec_waddr,
  output logic [core_pkg::xlen-1:0] dec_rdata1,
  output logic [core_pkg::xlen-1:0] dec_rdata2,
  output core_pkg::alu_op_t         dec_alu_op,
  output core_pkg::lsu_op_t         dec_lsu_op,
  output logic                      dec_jump,
  output logic                      dec_exception,
  output core_pkg::ecause_t         dec_ecause
);
  import core_pkg::*;

  // predecoder results.
  logic        pd_valid;
  logic [31:0] pd_imm;
  logic        pd_wren;
  logic        pd_rden1;
  logic        pd_rden2;
  logic        pd_lui;
  logic        pd_auipc;
  logic        pd_jal;
  logic        pd_jalr;
  logic        pd_branch;
  logic        pd_load;
  logic        pd_store;
  alu_op_t     pd_alu_op;
  bcu_op_t     pd_bcu_op;
  lsu_op_t     pd_lsu_op;

  logic [31:0]     instr;
  logic [4:0]      raddr1;
  logic [4:0]      raddr2;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  bcu_op_t         bcu_op;
  logic            taken;
  logic [xlen-1:0] pc;
  logic [31:0]     imm;
  logic            jal;
  logic            jalr;
  logic            branch;
  logic            auipc;
  lsu_op_t         lsu_op;
  logic [xlen-1:0] address;
  logic [3:0]      byteenable;
  logic [xlen-1:0] agu_wdata;
  logic            exception;
  ecause_t         ecause;

  fetch_stage u_fetch_stage (.*);

  predecoder u_predecoder (
    .instr  (instr),
    .valid  (pd_valid),
    .imm    (pd_imm),
    .wren   (pd_wren),
    .rden1  (pd_rden1),
    .rden2  (pd_rden2),
    .lui    (pd_lui),
    .auipc  (pd_auipc),
    .jal    (pd_jal),
    .jalr   (pd_jalr),
    .branch (pd_branch),
    .load   (pd_load),
    .store  (pd_store),
    .alu_op (pd_alu_op),
    .bcu_op (pd_bcu_op),
    .lsu_op (pd_lsu_op)
  );

  register_file u_register_file (
    .clk    (clk),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .waddr  (wb_waddr),
    .wren   (wb_wren),
    .wdata  (wb_wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  bcu u_bcu (.*);

  agu u_agu (
    .pc         (pc),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .imm        (imm),
    .jal        (jal),
    .jalr       (jalr),
    .branch     (branch),
    .auipc      (auipc),
    .lsu_op     (lsu_op),
    .address    (address),
    .byteenable (byteenable),
    .wdata      (agu_wdata),
    .exception  (exception),
    .ecause     (ecause)
  );

endmodule

//--- testbench/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;
  import core_pkg::*;

  localparam int run_cycles = 3000;
  localparam int max_cycles = 4000;
  localparam int idle_limit = 64;

  logic            clk;
  logic            rst;
  logic [31:0]     imem_rdata;
  logic            imem_ready;
  logic            stall;
  logic            clear;
  logic            wb_wren;
  logic [4:0]      wb_waddr;
  logic [xlen-1:0] wb_wdata;
  logic [xlen-1:0] imem_addr;
  logic            dmem_valid;
  logic [xlen-1:0] dmem_addr;
  logic [xlen-1:0] dmem_wdata;
  logic [3:0]      dmem_wstrb;
  logic            dec_valid;
  logic [xlen-1:0] dec_pc;
  logic [31:0]     dec_instr;
  logic [31:0]     dec_imm;
  logic            dec_wren;
  logic [4:0]      dec_waddr;
  logic [xlen-1:0] dec_rdata1;
  logic [xlen-1:0] dec_rdata2;
  alu_op_t         dec_alu_op;
  lsu_op_t         dec_lsu_op;
  logic            dec_jump;
  logic            dec_exception;
  ecause_t         dec_ecause;

  logic [31:0] rng;
  logic [31:0] imem [0:255]; // aliased over the whole address space.
  logic [31:0] m_regs [0:31];
  logic [31:0] m_pc;

  // expected registered decode.
  logic        exp_valid;
  logic [31:0] exp_pc;
  logic [31:0] exp_instr;
  logic [31:0] exp_imm;
  logic        exp_wren;
  logic [4:0]  exp_waddr;
  logic [31:0] exp_rd1;
  logic [31:0] exp_rd2;
  alu_op_t     exp_alu;
  lsu_op_t     exp_lsu;
  logic        exp_jump;
  logic        exp_exc;
  ecause_t     exp_ecause;

  fetch_top dut (.*);

  assign imem_rdata = imem[imem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ############################################################
  // helpers
  // ############################################################

  function logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] make_instr();
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] ins;
    logic [2:0]  f3;
    logic [6:0]  hi;
    r = next_rand();
    s = next_rand();
    f3 = r[14:12];
    case (s[2:0])
      3'd0: begin // register form.
        hi = ((f3 == 3'd0 || f3 == 3'd5) && s[4]) ? 7'h20 : 7'h00;
        ins = {hi, r[24:15], f3, r[11:7], 7'b0110011};
      end
      3'd1: begin
        hi = (f3 == 3'd5) ? (s[4] ? 7'h20 : 7'h00) : r[31:25];
        if (f3 == 3'd1) begin
          hi = 7'h00;
        end
        ins = {hi, r[24:15], f3, r[11:7], 7'b0010011};
      end
      3'd2: ins = {r[31:7], 7'b0110111};
      3'd3: begin
        if (f3[2:1] == 2'b01) begin
          f3 = {2'b00, f3[0]};
        end
        ins = {r[31:15], f3, r[11:7], 7'b1100011};
        ins[8] = ins[8] & (s[5:4] == 2'b00); // offset bit 1.
      end
      3'd4: begin
        ins = {r[31:7], 7'b1101111};
        ins[21] = ins[21] & (s[5:4] == 2'b00);
      end
      3'd5: begin
        ins = {r[31:15], 3'b000, r[11:7], 7'b1100111};
        ins[21] = ins[21] & (s[5:4] == 2'b00);
      end
      3'd6: begin
        if (f3 == 3'b011) begin
          f3 = 3'b010;
        end else if (f3[2:1] == 2'b11) begin
          f3 = {2'b10, f3[0]};
        end
        ins = {r[31:15], f3, r[11:7], 7'b0000011};
        ins[21:20] = (s[5:4] == 2'b00) ? ins[21:20] : 2'b00;
      end
      default: begin
        f3 = (r[13:12] == 2'b11) ? 3'b010 : {1'b0, r[13:12]};
        ins = {r[31:15], f3, r[11:7], 7'b0100011};
        ins[8:7] = (s[5:4] == 2'b00) ? ins[8:7] : 2'b00;
      end
    endcase
    return ins;
  endfunction

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_dec();
    check_value("dec_valid", dec_valid, exp_valid);
    check_value("dec_pc", dec_pc, exp_pc);
    check_value("dec_instr", dec_instr, exp_instr);
    check_value("dec_imm", dec_imm, exp_imm);
    check_value("dec_wren", dec_wren, exp_wren);
    check_value("dec_waddr", dec_waddr, exp_waddr);
    check_value("dec_rdata1", dec_rdata1, exp_rd1);
    check_value("dec_rdata2", dec_rdata2, exp_rd2);
    check_value("dec_alu_op", dec_alu_op, exp_alu);
    check_value("dec_lsu_op", dec_lsu_op, exp_lsu);
    check_value("dec_jump", dec_jump, exp_jump);
    check_value("dec_exception", dec_exception, exp_exc);
    if (exp_exc) begin
      check_value("dec_ecause", dec_ecause, exp_ecause);
    end
  endtask

  // ############################################################
  // reference model of one fetch cycle
  // ############################################################

  task automatic predict(output logic accepted);
    logic [31:0] ins;
    logic [31:0] imm;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] addr;
    logic [31:0] wdat;
    logic [3:0]  bytes;
    logic [2:0]  f3;
    logic        stalled;
    logic        wr;
    logic        rd1_en;
    logic        rd2_en;
    logic        tk;
    logic        jump;
    logic        mis;
    logic        exc;
    logic        dv;
    alu_op_t     alu;
    lsu_op_t     lsu;
    ins = clear ? nop_instr : imem[m_pc[9:2]];
    f3 = ins[14:12];
    r1 = m_regs[ins[19:15]];
    r2 = m_regs[ins[24:20]];
    stalled = ~imem_ready | stall | clear;
    imm = {{20{ins[31]}}, ins[31:20]};
    wr = 1'b0;
    rd1_en = 1'b0;
    rd2_en = 1'b0;
    tk = 1'b0;
    alu = alu_add;
    lsu = lsu_none;
    case (ins[6:0])
      opc_lui: begin
        imm = {ins[31:12], 12'h000};
        wr = 1'b1;
      end
      opc_jal: begin
        imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        wr = 1'b1;
      end
      opc_jalr: begin
        wr = 1'b1;
        rd1_en = 1'b1;
      end
      opc_branch: begin
        imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        rd1_en = 1'b1;
        rd2_en = 1'b1;
        case (f3)
          3'b000: tk = (r1 == r2);
          3'b001: tk = (r1 != r2);
          3'b100: tk = ($signed(r1) < $signed(r2));
          3'b101: tk = ($signed(r1) >= $signed(r2));
          3'b110: tk = (r1 < r2);
          default: tk = (r1 >= r2);
        endcase
      end
      opc_load: begin
        wr = 1'b1;
        rd1_en = 1'b1;
        lsu = (f3 == 3'b000) ? lsu_lb : (f3 == 3'b001) ? lsu_lh :
              (f3 == 3'b010) ? lsu_lw : (f3 == 3'b100) ? lsu_lbu : lsu_lhu;
      end
      opc_store: begin
        imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        rd1_en = 1'b1;
        rd2_en = 1'b1;
        lsu = (f3 == 3'b000) ? lsu_sb : (f3 == 3'b001) ? lsu_sh : lsu_sw;
      end
      default: begin // op_imm and op.
        wr = 1'b1;
        rd1_en = 1'b1;
        rd2_en = ins[5];
        case (f3)
          3'b000: alu = (ins[5] && ins[30]) ? alu_sub : alu_add;
          3'b001: alu = alu_sll;
          3'b010: alu = alu_slt;
          3'b011: alu = alu_sltu;
          3'b100: alu = alu_xor;
          3'b101: alu = ins[30] ? alu_sra : alu_srl;
          3'b110: alu = alu_or;
          default: alu = alu_and;
        endcase
      end
    endcase
    jump = (ins[6:0] == opc_jal) | (ins[6:0] == opc_jalr) | tk;
    if (ins[6:0] == opc_jalr) begin
      addr = r1 + imm;
      addr[0] = 1'b0; // jalr drops the low target bit.
    end else if ((ins[6:0] == opc_jal) || (ins[6:0] == opc_branch)) begin
      addr = m_pc + imm;
    end else begin
      addr = r1 + imm;
    end
    bytes = 4'hf;
    wdat = r2;
    mis = |addr[1:0];
    if (lsu inside {lsu_lb, lsu_lbu, lsu_sb}) begin
      bytes = 4'h0;
      bytes[addr[1:0]] = 1'b1;
      wdat = {r2[7:0], r2[7:0], r2[7:0], r2[7:0]};
      mis = 1'b0;
    end else if (lsu inside {lsu_lh, lsu_lhu, lsu_sh}) begin
      bytes = addr[1] ? 4'b1100 : 4'b0011;
      wdat = {r2[15:0], r2[15:0]};
      mis = addr[0];
    end
    exc = ~stalled & ((jump & |addr[1:0]) | ((lsu != lsu_none) & mis));
    dv = ~stalled & (lsu != lsu_none) & ~exc;

    // data memory request of this same cycle.
    check_value("dmem_valid", dmem_valid, dv);
    if (dv) begin
      check_value("dmem_addr", dmem_addr, addr);
      check_value("dmem_wstrb", dmem_wstrb, (ins[6:0] == opc_store) ? bytes : 4'h0);
      if (ins[6:0] == opc_store) begin
        check_value("dmem_wdata", dmem_wdata, wdat);
      end
    end

    exp_valid = ~stalled;
    exp_pc = m_pc;
    exp_instr = ins;
    exp_imm = imm;
    exp_wren = ~stalled & wr & ~exc;
    exp_waddr = ins[11:7];
    exp_rd1 = rd1_en ? r1 : 32'h0;
    exp_rd2 = rd2_en ? r2 : 32'h0;
    exp_alu = alu;
    exp_lsu = (stalled || exc) ? lsu_none : lsu;
    exp_jump = ~stalled & jump & ~exc;
    exp_exc = exc;
    exp_ecause = jump ? exc_instr_misaligned :
                 (ins[6:0] == opc_store) ? exc_store_misaligned : exc_load_misaligned;

    if (exc) begin
      m_pc = trap_vector;
    end else if (!stalled && jump) begin
      m_pc = addr;
    end else if (!stalled) begin
      m_pc = m_pc + 32'd4;
    end
    accepted = ~stalled;
  endtask

  // ############################################################
  // stimulus
  // ############################################################

  initial begin
    int          i;
    int          idle;
    logic        accepted;
    logic        refresh;
    logic [7:0]  refresh_idx;
    logic [31:0] r;
    rng = 32'hb456cb3d;
    rst = 1'b0;
    stall = 1'b1;
    clear = 1'b0;
    imem_ready = 1'b0;
    wb_wren = 1'b0;
    wb_waddr = 5'd0;
    wb_wdata = '0;
    for (i = 0; i < 256; i++) begin
      imem[i] = make_instr();
    end
    m_regs[0] = 32'h0;
    repeat (10) @(negedge clk);
    check_value("imem_addr", imem_addr, reset_vector);
    check_value("dec_valid", dec_valid, 1'b0);
    check_value("dec_wren", dec_wren, 1'b0);
    check_value("dec_jump", dec_jump, 1'b0);
    check_value("dec_exception", dec_exception, 1'b0);
    check_value("dmem_valid", dmem_valid, 1'b0);
    rst = 1'b1;

    // half the registers hold word aligned values.
    for (i = 1; i < 32; i++) begin
      @(negedge clk);
      r = next_rand();
      if (i < 16) begin
        r[1:0] = 2'b00;
      end
      wb_wren = 1'b1;
      wb_waddr = i[4:0];
      wb_wdata = r;
      m_regs[i] = r;
    end
    @(negedge clk);
    wb_wren = 1'b0;
    check_value("imem_addr", imem_addr, reset_vector);

    m_pc = reset_vector;
    refresh = 1'b0;
    refresh_idx = 8'd0;
    idle = 0;
    for (i = 0; i < run_cycles; i++) begin
      @(negedge clk);
      if (i > 0) begin
        compare_dec();
      end
      if (refresh) begin
        imem[refresh_idx] = make_instr(); // fresh code behind the pc.
      end
      r = next_rand();
      stall = (r[2:0] == 3'd0);
      imem_ready = (r[5:3] != 3'd0);
      clear = (r[9:6] == 4'd0);
      #1;
      check_value("imem_addr", imem_addr, m_pc);
      refresh_idx = m_pc[9:2];
      predict(accepted);
      refresh = accepted;
      idle = accepted ? 0 : idle + 1;
      if (idle > idle_limit) begin
        $display("no instruction was accepted for %0d cycles", idle_limit);
        abort_run();
      end
    end
    @(negedge clk);
    compare_dec();
    $display("Done: no errors");
    $finish;
  end

  initial begin
    int n;
    for (n = 0; n < max_cycles; n++) begin
      @(posedge clk);
    end
    $display("simulation did not finish within %0d cycles", max_cycles);
    abort_run();
  end

endmodule

//--- vlog.f
hdl/core_pkg.sv
hdl/predecoder.sv
hdl/register_file.sv
hdl/bcu.sv
hdl/agu.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
testbench/fetch_tb.sv
